//--- hood_time_pkg.sv
package hood_time_pkg;

    // hh:mm:ss, two bcd digits per field
    typedef logic [23:0] bcd_time_t;

    // two-digit bcd seconds, storm and exit-storm countdown
    typedef logic [7:0] bcd_sec_t;

    // three-digit bcd seconds, clean countdown
    typedef logic [11:0] bcd_long_t;

    localparam bcd_sec_t STORM_START = 8'h60;       // 60 s boost / run-on
    localparam bcd_long_t CLEAN_START = 12'h180;    // 180 s self-clean

    // reminder once the hood has worked for an hour
    localparam bcd_time_t REMIND_TIME = 24'h01_00_00;

    localparam int LONG_PRESS_TICKS = 3;            // ticks of held x for power off

    // 100 MHz board clock
    localparam int unsigned TICK_DIV_DEFAULT = 100_000_000;

endpackage

//--- hood_mode_pkg.sv
package hood_mode_pkg;

    typedef enum logic [2:0] {
        SHUTDOWN,
        STANDBY,
        MENU,
        GEAR_ONE,
        GEAR_TWO,
        STORM,       // one-shot boost
        EXIT_STORM,  // run-on before standby
        CLEAN
    } mode_t;

    // low byte of the display word
    typedef logic [7:0] show_code_t;

    localparam show_code_t SHOW_STAN       = 8'h01;
    localparam show_code_t SHOW_MENU       = 8'h02;
    localparam show_code_t SHOW_ONE        = 8'h11;
    localparam show_code_t SHOW_TWO        = 8'h12;
    localparam show_code_t SHOW_THREE      = 8'h13;  // storm screen
    localparam show_code_t SHOW_EXIT_STORM = 8'h14;
    localparam show_code_t SHOW_CLEAN      = 8'h20;

endpackage

//--- hood_ifs.sv
`timescale 1ns/1ps

// key commands, one-cycle registered pulses
interface hood_cmd_if;
    logic power_on;
    logic power_off;
    logic key_w;
    logic key_a;
    logic key_s;
    logic key_d;
    logic key_x;

    modport src (
        output power_on, power_off,
        output key_w, key_a, key_s, key_d, key_x
    );

    modport dst (
        input power_on, power_off,
        input key_w, key_a, key_s, key_d, key_x
    );
endinterface

// mode and countdown handshake between fsm and timers
interface hood_ctrl_if import hood_mode_pkg::*; ();
    mode_t mode;
    logic  storm_load;   // pulse, reload storm count
    logic  clean_load;   // pulse, reload clean count
    logic  storm_done;   // level, storm count at zero
    logic  clean_done;

    modport ctl (
        output mode, storm_load, clean_load,
        input  storm_done, clean_done
    );

    modport tmr (
        input  mode, storm_load, clean_load,
        output storm_done, clean_done
    );
endinterface

//--- key_decode.sv
`timescale 1ns/1ps

module key_decode import hood_time_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic btn_w,
    input  logic btn_a,
    input  logic btn_s,
    input  logic btn_d,
    input  logic btn_x,
    input  logic x_release,
    input  logic switch_p,
    input  logic hood_on,
    input  logic tick,
    output logic clear_work,
    hood_cmd_if.src cmd
);

    logic holding;  // x held for power off
    logic [$clog2(LONG_PRESS_TICKS + 1)-1:0] press_cnt;
    logic press_done;

    assign press_done = holding && tick && (int'(press_cnt) == LONG_PRESS_TICKS - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cmd.key_w     <= 1'b0;
            cmd.key_a     <= 1'b0;
            cmd.key_s     <= 1'b0;
            cmd.key_d     <= 1'b0;
            cmd.key_x     <= 1'b0;
            cmd.power_on  <= 1'b0;
            cmd.power_off <= 1'b0;
            clear_work    <= 1'b0;
            holding       <= 1'b0;
            press_cnt     <= '0;
        end else begin
            cmd.key_w <= btn_w & ~switch_p;
            cmd.key_a <= btn_a & ~switch_p;
            cmd.key_s <= btn_s & ~switch_p;
            cmd.key_d <= btn_d & ~switch_p;
            cmd.key_x <= btn_x & ~switch_p;

            cmd.power_on  <= btn_x & switch_p & ~hood_on;  // only from shutdown
            cmd.power_off <= press_done;
            clear_work    <= btn_s & switch_p;

            if (btn_x && switch_p && hood_on && !holding) begin
                holding   <= 1'b1;
                press_cnt <= '0;
            end else if (x_release || !switch_p || !hood_on || press_done) begin
                holding   <= 1'b0;
                press_cnt <= '0;
            end else if (holding && tick) begin
                press_cnt <= press_cnt + 1'b1;
            end
        end
    end

    // power on needs the hood off, a long press needs it on
    a_on_off_excl: assert property (@(posedge clk) disable iff (!rst)
        !(cmd.power_on && cmd.power_off));

endmodule

//--- mode_fsm.sv
`timescale 1ns/1ps

module mode_fsm import hood_mode_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic hood_on,
    hood_cmd_if.dst  cmd,
    hood_ctrl_if.ctl ctrl
);

    mode_t mode;
    mode_t mode_next;
    logic  storm_once;  // boost already used since power on

    assign ctrl.mode = mode;
    assign hood_on   = (mode != SHUTDOWN);

    always_comb begin
        mode_next       = mode;
        ctrl.storm_load = 1'b0;
        ctrl.clean_load = 1'b0;
        if (cmd.power_off) begin
            mode_next = SHUTDOWN;
        end else begin
            case (mode)
                SHUTDOWN: begin
                    if (cmd.power_on)
                        mode_next = STANDBY;
                end
                STANDBY: begin
                    if (cmd.key_w)
                        mode_next = MENU;
                end
                MENU: begin
                    if (cmd.key_a) begin
                        mode_next = GEAR_ONE;
                    end else if (cmd.key_s) begin
                        mode_next = GEAR_TWO;
                    end else if (cmd.key_d && !storm_once) begin
                        mode_next       = STORM;
                        ctrl.storm_load = 1'b1;
                    end else if (cmd.key_x) begin
                        mode_next       = CLEAN;
                        ctrl.clean_load = 1'b1;
                    end
                end
                GEAR_ONE: begin
                    if (cmd.key_s)
                        mode_next = GEAR_TWO;
                    else if (cmd.key_w)
                        mode_next = STANDBY;
                end
                GEAR_TWO: begin
                    if (cmd.key_a)
                        mode_next = GEAR_ONE;
                    else if (cmd.key_w)
                        mode_next = STANDBY;
                end
                STORM: begin
                    if (cmd.key_w) begin
                        mode_next       = EXIT_STORM;
                        ctrl.storm_load = 1'b1;  // restart count for run-on
                    end else if (ctrl.storm_done) begin
                        mode_next = GEAR_TWO;
                    end
                end
                EXIT_STORM: begin
                    if (ctrl.storm_done)
                        mode_next = STANDBY;
                end
                CLEAN: begin
                    if (ctrl.clean_done)
                        mode_next = STANDBY;
                end
                default: mode_next = SHUTDOWN;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode       <= SHUTDOWN;
            storm_once <= 1'b0;
        end else begin
            mode <= mode_next;
            if (cmd.power_off)
                storm_once <= 1'b0;
            else if (ctrl.storm_load)
                storm_once <= 1'b1;
        end
    end

    // once used, storm may only be reloaded for the run-on
    a_storm_once: assert property (@(posedge clk) disable iff (!rst)
        ctrl.storm_load && storm_once |-> mode == STORM);

    // timer picks up the load in step with the mode change
    a_storm_loaded: assert property (@(posedge clk) disable iff (!rst)
        ctrl.storm_load |=> mode inside {STORM, EXIT_STORM} && !ctrl.storm_done);

endmodule

//--- time_display.sv
`timescale 1ns/1ps

module time_display import hood_time_pkg::*, hood_mode_pkg::*; #(
    parameter int unsigned tick_div = TICK_DIV_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear_work,
    output logic        tick,
    output logic        reminder,
    output logic [31:0] sign,
    hood_ctrl_if.tmr    ctrl
);

    logic [$clog2(tick_div)-1:0] div_cnt;
    bcd_time_t clock_time;
    bcd_time_t work_time;
    bcd_sec_t  storm_cnt;
    bcd_long_t clean_cnt;
    bcd_long_t storm_step;
    bcd_long_t clean_step;
    logic      working;

    // hh:mm:ss plus one second, wraps after 23:59:59
    function automatic bcd_time_t bcd_inc(bcd_time_t t);
        bcd_time_t r;
        r = t;
        if (t[3:0] != 4'd9) begin
            r[3:0] = t[3:0] + 4'd1;
        end else begin
            r[3:0] = 4'd0;
            if (t[7:4] != 4'd5) begin
                r[7:4] = t[7:4] + 4'd1;
            end else begin
                r[7:4] = 4'd0;
                if (t[11:8] != 4'd9) begin
                    r[11:8] = t[11:8] + 4'd1;
                end else begin
                    r[11:8] = 4'd0;
                    if (t[15:12] != 4'd5) begin
                        r[15:12] = t[15:12] + 4'd1;
                    end else begin
                        r[15:12] = 4'd0;
                        if (t[23:16] == 8'h23)
                            r[23:16] = 8'h00;
                        else if (t[19:16] != 4'd9)
                            r[19:16] = t[19:16] + 4'd1;
                        else
                            r[23:16] = {t[23:20] + 4'd1, 4'd0};
                    end
                end
            end
        end
        return r;
    endfunction

    // three-digit bcd minus one, caller keeps it off zero
    function automatic bcd_long_t bcd_dec(bcd_long_t v);
        bcd_long_t r;
        r = v;
        if (v[3:0] != 4'd0) begin
            r[3:0] = v[3:0] - 4'd1;
        end else begin
            r[3:0] = 4'd9;
            if (v[7:4] != 4'd0)
                r[7:4] = v[7:4] - 4'd1;
            else
                r[11:4] = {v[11:8] - 4'd1, 4'd9};
        end
        return r;
    endfunction

    assign storm_step = bcd_dec({4'h0, storm_cnt});
    assign clean_step = bcd_dec(clean_cnt);
    assign working    = ctrl.mode inside {GEAR_ONE, GEAR_TWO, STORM, EXIT_STORM};

    assign ctrl.storm_done = (storm_cnt == '0);
    assign ctrl.clean_done = (clean_cnt == '0);
    assign reminder        = (work_time >= REMIND_TIME);  // bcd keeps numeric order

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (32'(div_cnt) == tick_div - 1) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            clock_time <= '0;
            work_time  <= '0;
        end else if (ctrl.mode == SHUTDOWN) begin
            clock_time <= '0;
            work_time  <= '0;
        end else begin
            if (tick)
                clock_time <= bcd_inc(clock_time);
            if (clear_work || (ctrl.mode == CLEAN && ctrl.clean_done))
                work_time <= '0;
            else if (tick && working)
                work_time <= bcd_inc(work_time);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            storm_cnt <= '0;
            clean_cnt <= '0;
        end else begin
            if (ctrl.storm_load)
                storm_cnt <= STORM_START;
            else if (!(ctrl.mode inside {STORM, EXIT_STORM}))
                storm_cnt <= '0;
            else if (tick && !ctrl.storm_done)
                storm_cnt <= storm_step[7:0];

            if (ctrl.clean_load)
                clean_cnt <= CLEAN_START;
            else if (ctrl.mode != CLEAN)
                clean_cnt <= '0;
            else if (tick && !ctrl.clean_done)
                clean_cnt <= clean_step;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sign <= {24'h0, SHOW_STAN};
        end else begin
            case (ctrl.mode)
                MENU:       sign <= {clock_time, SHOW_MENU};
                GEAR_ONE:   sign <= {clock_time, SHOW_ONE};
                GEAR_TWO:   sign <= {clock_time, SHOW_TWO};
                STORM:      sign <= {16'h0, storm_cnt, SHOW_THREE};
                EXIT_STORM: sign <= {16'h0, storm_cnt, SHOW_EXIT_STORM};
                CLEAN:      sign <= {12'h0, clean_cnt, SHOW_CLEAN};
                default:    sign <= {clock_time, SHOW_STAN};  // shutdown, standby
            endcase
        end
    end

    // loads and decrements must keep every digit decimal
    a_bcd_digits: assert property (@(posedge clk) disable iff (!rst)
        storm_cnt[3:0] <= 4'd9 && storm_cnt[7:4] <= 4'd9 &&
        clean_cnt[3:0] <= 4'd9 && clean_cnt[7:4] <= 4'd9 && clean_cnt[11:8] <= 4'd9);

endmodule

//--- hood_top.sv
`timescale 1ns/1ps

module hood_top import hood_time_pkg::*; #(
    parameter int unsigned tick_div = TICK_DIV_DEFAULT
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_w,
    input  logic        btn_a,
    input  logic        btn_s,
    input  logic        btn_d,
    input  logic        btn_x,
    input  logic        x_release,
    input  logic        switch_p,
    output logic [31:0] sign,
    output logic        opening,
    output logic        reminder
);

    logic tick;
    logic clear_work;

    hood_cmd_if  cmd_bus ();
    hood_ctrl_if ctrl_bus ();

    key_decode u_key_decode (
        .clk        (clk),
        .rst        (rst),
        .btn_w      (btn_w),
        .btn_a      (btn_a),
        .btn_s      (btn_s),
        .btn_d      (btn_d),
        .btn_x      (btn_x),
        .x_release  (x_release),
        .switch_p   (switch_p),
        .hood_on    (opening),
        .tick       (tick),
        .clear_work (clear_work),
        .cmd        (cmd_bus.src)
    );

    mode_fsm u_mode_fsm (
        .clk     (clk),
        .rst     (rst),
        .hood_on (opening),  // hood running drives the opening output
        .cmd     (cmd_bus.dst),
        .ctrl    (ctrl_bus.ctl)
    );

    time_display #(
        .tick_div (tick_div)
    ) u_time_display (
        .clk        (clk),
        .rst        (rst),
        .clear_work (clear_work),
        .tick       (tick),
        .reminder   (reminder),
        .sign       (sign),
        .ctrl       (ctrl_bus.tmr)
    );

endmodule

//--- tb_hood_top.sv
`timescale 1ns/1ps

module tb_hood_top import hood_time_pkg::*, hood_mode_pkg::*; ();

    localparam int TICK_DIV   = 4;
    localparam int CLK_PERIOD = 100;
    localparam int RUN_CYCLES = 20_000;            // dominated by the one-hour work run
    localparam int STEP_LIMIT = 2 * TICK_DIV + 4;  // max cycles between countdown steps

    logic        clk;
    logic        rst;
    logic        btn_w;
    logic        btn_a;
    logic        btn_s;
    logic        btn_d;
    logic        btn_x;
    logic        x_release;
    logic        switch_p;
    logic [31:0] sign;
    logic        opening;
    logic        reminder;

    // each check is live while its flag is high
    logic       chk_code;
    logic       chk_value;
    logic       chk_open;
    logic       chk_remind;
    logic       chk_min;
    show_code_t exp_code;
    bcd_time_t  exp_value;
    logic       exp_open;
    logic       exp_remind;

    int errors;
    int errors_at_start;
    int tests;
    int failed;

    hood_top #(
        .tick_div (TICK_DIV)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .btn_w     (btn_w),
        .btn_a     (btn_a),
        .btn_s     (btn_s),
        .btn_d     (btn_d),
        .btn_x     (btn_x),
        .x_release (x_release),
        .switch_p  (switch_p),
        .sign      (sign),
        .opening   (opening),
        .reminder  (reminder)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    a_code: assert property (@(posedge clk) disable iff (!rst)
        chk_code |-> sign[7:0] == exp_code)
        else begin
            $display("MISMATCH sign[7:0] expected %h got %h", exp_code, $sampled(sign[7:0]));
            errors++;
        end

    a_value: assert property (@(posedge clk) disable iff (!rst)
        chk_value |-> sign[31:8] == exp_value)
        else begin
            $display("MISMATCH sign[31:8] expected %h got %h", exp_value, $sampled(sign[31:8]));
            errors++;
        end

    a_open: assert property (@(posedge clk) disable iff (!rst)
        chk_open |-> opening == exp_open)
        else begin
            $display("MISMATCH opening expected %h got %h", exp_open, $sampled(opening));
            errors++;
        end

    a_remind: assert property (@(posedge clk) disable iff (!rst)
        chk_remind |-> reminder == exp_remind)
        else begin
            $display("MISMATCH reminder expected %h got %h", exp_remind, $sampled(reminder));
            errors++;
        end

    // clock has run at least as long as the work time
    a_clock_min: assert property (@(posedge clk) disable iff (!rst)
        chk_min |-> sign[31:8] >= REMIND_TIME)
        else begin
            $display("MISMATCH sign[31:8] expected >= %h got %h", REMIND_TIME,
                     $sampled(sign[31:8]));
            errors++;
        end

    function automatic bcd_time_t to_bcd(input int n);
        return {12'h0, 4'(n / 100), 4'((n / 10) % 10), 4'(n % 10)};
    endfunction

    function automatic int bcd_value(input logic [11:0] v);
        return 100 * int'(v[11:8]) + 10 * int'(v[7:4]) + int'(v[3:0]);
    endfunction

    function automatic int time_seconds(input bcd_time_t t);
        return 3600 * (10 * int'(t[23:20]) + int'(t[19:16]))
             + 60 * (10 * int'(t[15:12]) + int'(t[11:8]))
             + 10 * int'(t[7:4]) + int'(t[3:0]);
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one-cycle button pulse from one falling edge to the next
    task automatic pulse_button(input byte key);
        case (key)
            "w": btn_w = 1'b1;
            "a": btn_a = 1'b1;
            "s": btn_s = 1'b1;
            "d": btn_d = 1'b1;
            "x": btn_x = 1'b1;
            "r": x_release = 1'b1;
            default: ;
        endcase
        @(negedge clk);
        btn_w     = 1'b0;
        btn_a     = 1'b0;
        btn_s     = 1'b0;
        btn_d     = 1'b0;
        btn_x     = 1'b0;
        x_release = 1'b0;
    endtask

    task automatic check_code(input show_code_t code);
        exp_code = code;
        chk_code = 1'b1;
        @(negedge clk);
        chk_code = 1'b0;
    endtask

    task automatic check_display(input show_code_t code, input bcd_time_t value);
        exp_code  = code;
        exp_value = value;
        chk_code  = 1'b1;
        chk_value = 1'b1;
        @(negedge clk);
        chk_code  = 1'b0;
        chk_value = 1'b0;
    endtask

    task automatic check_open(input logic level);
        exp_open = level;
        chk_open = 1'b1;
        @(negedge clk);
        chk_open = 1'b0;
    endtask

    task automatic check_remind(input logic level);
        exp_remind = level;
        chk_remind = 1'b1;
        @(negedge clk);
        chk_remind = 1'b0;
    endtask

    // screen follows three cycles after the button
    task automatic key_then_screen(input byte key, input show_code_t code);
        pulse_button(key);
        idle(2);
        check_code(code);
    endtask

    task automatic wait_code(input show_code_t code, input int limit);
        int n;
        n = 0;
        while (sign[7:0] != code && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (sign[7:0] != code) begin
            $display("timeout waiting for screen code %h", code);
            errors++;
        end
    endtask

    task automatic wait_change(input int limit);
        logic [31:0] prev;
        int          n;
        prev = sign;
        n    = 0;
        while (sign == prev && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (sign == prev) begin
            $display("display did not change within %0d cycles", limit);
            errors++;
        end
    endtask

    // "o" for opening, "r" for reminder
    task automatic wait_level(input byte which, input logic level, input int limit);
        int n;
        n = 0;
        while ((which == "o" ? opening : reminder) != level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ((which == "o" ? opening : reminder) != level) begin
            $display("timeout waiting for %s to go %0d", which == "o" ? "opening" : "reminder",
                     level);
            errors++;
        end
    endtask

    // every displayed count from start down to zero at one step per tick
    task automatic follow_countdown(input show_code_t code, input int start);
        wait_code(code, 8);
        check_display(code, to_bcd(start));
        for (int n = start - 1; n >= 0; n--) begin
            wait_change(STEP_LIMIT);
            check_display(code, to_bcd(n));
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %-12s ok", name);
        end else begin
            failed++;
            $display("test %-12s failed, %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 3 / 2);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst        = 1'b0;
        btn_w      = 1'b0;
        btn_a      = 1'b0;
        btn_s      = 1'b0;
        btn_d      = 1'b0;
        btn_x      = 1'b0;
        x_release  = 1'b0;
        switch_p   = 1'b0;
        chk_code   = 1'b0;
        chk_value  = 1'b0;
        chk_open   = 1'b0;
        chk_remind = 1'b0;
        chk_min    = 1'b0;
        exp_code   = '0;
        exp_value  = '0;
        exp_open   = 1'b0;
        exp_remind = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests           = 0;
        failed          = 0;

        repeat (10) @(negedge clk);
        rst = 1'b1;

        idle(1);
        check_open(1'b0);
        check_remind(1'b0);
        check_display(SHOW_STAN, '0);
        end_test("reset");

        switch_p = 1'b1;
        pulse_button("x");
        idle(1);
        check_open(1'b1);
        switch_p = 1'b0;
        key_then_screen("w", SHOW_MENU);
        key_then_screen("a", SHOW_ONE);
        key_then_screen("s", SHOW_TWO);
        key_then_screen("w", SHOW_STAN);
        end_test("power_menu");

        key_then_screen("w", SHOW_MENU);
        pulse_button("d");
        follow_countdown(SHOW_THREE, bcd_value({4'h0, STORM_START}));
        check_code(SHOW_TWO);
        key_then_screen("w", SHOW_STAN);
        key_then_screen("w", SHOW_MENU);
        key_then_screen("d", SHOW_MENU);  // boost already used
        end_test("storm");

        pulse_button("x");
        follow_countdown(SHOW_CLEAN, bcd_value(CLEAN_START));
        check_code(SHOW_STAN);
        end_test("clean");

        key_then_screen("w", SHOW_MENU);
        key_then_screen("a", SHOW_ONE);
        idle(TICK_DIV * (time_seconds(REMIND_TIME) - 1) - 3);
        check_remind(1'b0);  // one tick short
        wait_level("r", 1'b1, STEP_LIMIT);
        check_remind(1'b1);
        chk_min = 1'b1;
        @(negedge clk);
        chk_min  = 1'b0;
        switch_p = 1'b1;
        pulse_button("s");
        idle(1);
        check_remind(1'b0);
        switch_p = 1'b0;
        end_test("work_time");

        // short hold released after a single tick
        switch_p = 1'b1;
        pulse_button("x");
        idle(TICK_DIV);
        pulse_button("r");
        idle(LONG_PRESS_TICKS * TICK_DIV);
        check_open(1'b1);
        pulse_button("x");
        idle(TICK_DIV * (LONG_PRESS_TICKS - 1));
        check_open(1'b1);
        wait_level("o", 1'b0, STEP_LIMIT);
        pulse_button("r");
        switch_p = 1'b0;
        idle(1);
        check_open(1'b0);
        check_display(SHOW_STAN, '0);
        end_test("power_off");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- sim.f
hood_time_pkg.sv
hood_mode_pkg.sv
hood_ifs.sv
key_decode.sv
mode_fsm.sv
time_display.sv
hood_top.sv
tb_hood_top.sv

//--- Makefile
BIN  = obj_dir/Vtb_hood_top
SRCS = $(shell cat sim.f)

all: run

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_hood_top \
		-f sim.f -o Vtb_hood_top

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
